// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_commit
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
FAIL_MSG  ?= Done: errors found
PASS_MSG  ?= Done: no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f sim.f
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not complete"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim.f ====
src/commit_pkg.sv
src/flush_ctrl.sv
src/excp_report.sv
src/arch_rat.sv
src/commit_top.sv
tests/commit_assert.sv
tests/tb_commit.sv

// ==== src/arch_rat.sv ====
module arch_rat import commit_pkg::*; #(
  parameter int COMMIT_WIDTH = 2
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [COMMIT_WIDTH-1:0]       retire_mask_i,
  input  cmt_entry_t [COMMIT_WIDTH-1:0] cmt_i,
  input  areg_t                         raddr_i,
  output preg_t                         rdata_o,
  output free_t [COMMIT_WIDTH-1:0]      free_o
);

  // committed mapping, one physical register per architectural one
  preg_t rat_q [ARCH_REG_NUM];

  logic [COMMIT_WIDTH-1:0] wr_en;
  logic [COMMIT_WIDTH-1:0] free_valid_q;
  preg_t                   free_preg_q [COMMIT_WIDTH];

  // r0 has no real destination
  always_comb begin
    for (int i = 0; i < COMMIT_WIDTH; i++) begin
      wr_en[i] = retire_mask_i[i] & (cmt_i[i].arch_reg != '0);
    end
  end

  // ======================================================================
  // table update
  // ======================================================================
  // later slots overwrite earlier ones on the same register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int r = 0; r < ARCH_REG_NUM; r++) begin
        rat_q[r] <= preg_t'(r);
      end
    end else begin
      for (int i = 0; i < COMMIT_WIDTH; i++) begin
        if (wr_en[i]) begin
          rat_q[cmt_i[i].arch_reg] <= cmt_i[i].phy_reg;
        end
      end
    end
  end

  assign rdata_o = rat_q[raddr_i];

  // ======================================================================
  // free strobes
  // ======================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      free_valid_q <= '0;
    end else begin
      free_valid_q <= wr_en;
    end
  end

  // old mapping goes back to the free list
  always_ff @(posedge clk) begin
    for (int i = 0; i < COMMIT_WIDTH; i++) begin
      if (wr_en[i]) begin
        free_preg_q[i] <= cmt_i[i].old_phy_reg;
      end
    end
  end

  always_comb begin
    for (int i = 0; i < COMMIT_WIDTH; i++) begin
      free_o[i].valid = free_valid_q[i];
      free_o[i].preg  = free_preg_q[i];
    end
  end

endmodule

// ==== src/commit_pkg.sv ====
package commit_pkg;

  // ======================================================================
  // register file sizes
  // ======================================================================
  localparam int ARCH_REG_NUM = 32;
  localparam int PHY_REG_NUM  = 64;

  typedef logic [$clog2(ARCH_REG_NUM)-1:0] areg_t;
  typedef logic [$clog2(PHY_REG_NUM)-1:0]  preg_t;

  // exception codes as seen by the CSR file
  typedef enum logic [5:0] {
    ECODE_INT  = 6'h00,
    ECODE_PIL  = 6'h01,
    ECODE_PIS  = 6'h02,
    ECODE_PIF  = 6'h03,
    ECODE_PME  = 6'h04,
    ECODE_PPI  = 6'h07,
    ECODE_ADE  = 6'h08,
    ECODE_ALE  = 6'h09,
    ECODE_SYS  = 6'h0B,
    ECODE_BRK  = 6'h0C,
    ECODE_INE  = 6'h0D,
    ECODE_TLBR = 6'h3F
  } ecode_e;

  // ======================================================================
  // commit entry
  // ======================================================================
  // faulting address, split at the 8 KB page boundary
  typedef struct packed {
    logic [18:0] vppn;
    logic [12:0] offset;
  } bad_va_t;

  // branches carry a target here, faulting instructions carry their address
  typedef union packed {
    logic [31:0] br_target;
    bad_va_t     bad_va;
  } cmt_payload_u;

  typedef struct packed {
    logic [31:0]  pc;
    cmt_payload_u payload;
    logic         excp_valid;
    ecode_e       ecode;
    logic         br_redirect;
    logic         ertn;
    logic         ibar;
    logic         priv;
    logic         icacop;
    logic         idle;
    areg_t        arch_reg;
    preg_t        phy_reg;
    preg_t        old_phy_reg;
  } cmt_entry_t;

  // entry points coming from the CSR file
  typedef struct packed {
    logic [31:0] eentry;
    logic [31:0] tlbrentry;
    logic [31:0] era;
  } csr_vec_t;

  // ======================================================================
  // commit outputs
  // ======================================================================
  typedef struct packed {
    logic        valid;
    logic [31:0] target;
  } flush_t;

  typedef struct packed {
    logic        valid;
    logic        ertn;
    logic        tlbrefill;
    logic        tlb;
    logic [31:0] era;
    ecode_e      ecode;
    logic        va_error;
    logic [31:0] bad_va;
    logic [18:0] vppn;
  } excp_rpt_t;

  // one per commit slot, ports carry an array of these
  typedef struct packed {
    logic  valid;
    preg_t preg;
  } free_t;

endpackage

// ==== src/commit_top.sv ====
module commit_top import commit_pkg::*; #(
  parameter int COMMIT_WIDTH = 2
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [COMMIT_WIDTH-1:0]       cmt_valid_i,
  input  cmt_entry_t [COMMIT_WIDTH-1:0] cmt_i,
  input  csr_vec_t                      csr_i,
  input  logic                          int_pending_i,
  input  areg_t                         rat_raddr_i,
  output flush_t                        flush_o,
  output logic                          fetch_en_o,
  output excp_rpt_t                     excp_rpt_o,
  output free_t [COMMIT_WIDTH-1:0]      free_o,
  output preg_t                         rat_rdata_o
);

  logic [COMMIT_WIDTH-1:0] retire_mask;
  logic                    excp_cmt;
  logic                    ertn_cmt;

  // ======================================================================
  // flush decision and restart
  // ======================================================================
  flush_ctrl #(
    .COMMIT_WIDTH (COMMIT_WIDTH)
  ) u_flush_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .cmt_valid_i   (cmt_valid_i),
    .cmt_i         (cmt_i),
    .csr_i         (csr_i),
    .int_pending_i (int_pending_i),
    .flush_o       (flush_o),
    .fetch_en_o    (fetch_en_o),
    .retire_mask_o (retire_mask),
    .excp_cmt_o    (excp_cmt),
    .ertn_cmt_o    (ertn_cmt)
  );

  // report only ever describes slot 0
  excp_report u_excp_report (
    .clk        (clk),
    .rst_n      (rst_n),
    .excp_cmt_i (excp_cmt),
    .ertn_cmt_i (ertn_cmt),
    .entry_i    (cmt_i[0]),
    .rpt_o      (excp_rpt_o)
  );

  arch_rat #(
    .COMMIT_WIDTH (COMMIT_WIDTH)
  ) u_arch_rat (
    .clk           (clk),
    .rst_n         (rst_n),
    .retire_mask_i (retire_mask),
    .cmt_i         (cmt_i),
    .raddr_i       (rat_raddr_i),
    .rdata_o       (rat_rdata_o),
    .free_o        (free_o)
  );

endmodule

// ==== src/excp_report.sv ====
module excp_report import commit_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       excp_cmt_i,
  input  logic       ertn_cmt_i,
  input  cmt_entry_t entry_i,
  output excp_rpt_t  rpt_o
);

  logic [31:0] next_era;
  logic        next_va_error;
  logic        next_tlb;
  logic        next_tlbrefill;

  logic        valid_q;
  logic        ertn_q;
  logic        tlbrefill_q;
  logic        tlb_q;
  logic        va_error_q;
  logic [31:0] era_q;
  ecode_e      ecode_q;
  logic [31:0] bad_va_q;
  logic [18:0] vppn_q;

  // syscall and break resume after the trapping instruction
  always_comb begin
    next_era = (entry_i.ecode inside {ECODE_SYS, ECODE_BRK}) ? entry_i.pc + 32'd4
                                                              : entry_i.pc;
    next_va_error  = excp_cmt_i & (entry_i.ecode inside {ECODE_ADE, ECODE_TLBR, ECODE_PIF,
                                                         ECODE_PPI, ECODE_ALE, ECODE_PME,
                                                         ECODE_PIS, ECODE_PIL});
    next_tlb       = excp_cmt_i & (entry_i.ecode inside {ECODE_TLBR, ECODE_PIF, ECODE_PPI,
                                                         ECODE_PME, ECODE_PIS, ECODE_PIL});
    next_tlbrefill = excp_cmt_i & (entry_i.ecode == ECODE_TLBR);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q     <= 1'b0;
      ertn_q      <= 1'b0;
      tlbrefill_q <= 1'b0;
      tlb_q       <= 1'b0;
      va_error_q  <= 1'b0;
    end else begin
      valid_q     <= excp_cmt_i | ertn_cmt_i;
      ertn_q      <= ertn_cmt_i;
      tlbrefill_q <= next_tlbrefill;
      tlb_q       <= next_tlb;
      va_error_q  <= next_va_error;
    end
  end

  // payload is only meaningful while valid_q is set
  always_ff @(posedge clk) begin
    if (excp_cmt_i || ertn_cmt_i) begin
      era_q    <= next_era;
      ecode_q  <= entry_i.ecode;
      bad_va_q <= entry_i.payload.bad_va;
      vppn_q   <= entry_i.payload.bad_va.vppn;
    end
  end

  always_comb begin
    rpt_o.valid     = valid_q;
    rpt_o.ertn      = ertn_q;
    rpt_o.tlbrefill = tlbrefill_q;
    rpt_o.tlb       = tlb_q;
    rpt_o.era       = era_q;
    rpt_o.ecode     = ecode_q;
    rpt_o.va_error  = va_error_q;
    rpt_o.bad_va    = bad_va_q;
    rpt_o.vppn      = vppn_q;
  end

endmodule

// ==== src/flush_ctrl.sv ====
module flush_ctrl import commit_pkg::*; #(
  parameter int COMMIT_WIDTH = 2
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [COMMIT_WIDTH-1:0]       cmt_valid_i,
  input  cmt_entry_t [COMMIT_WIDTH-1:0] cmt_i,
  input  csr_vec_t                      csr_i,
  input  logic                          int_pending_i,
  output flush_t                        flush_o,
  output logic                          fetch_en_o,
  output logic [COMMIT_WIDTH-1:0]       retire_mask_o,
  output logic                          excp_cmt_o,
  output logic                          ertn_cmt_o
);

  // slot-0 flush kinds
  logic excp_flush;
  logic tlbrefill_flush;
  logic redirect_flush;
  logic ertn_flush;
  logic refetch_flush;
  logic idle_flush;
  logic any_flush;

  logic [31:0] restart_target;

  logic        flush_valid_q;
  logic [31:0] flush_target_q;
  logic        idle_lock_q;

  // ======================================================================
  // classify the oldest committing instruction
  // ======================================================================
  always_comb begin
    excp_flush      = cmt_valid_i[0] & cmt_i[0].excp_valid;
    tlbrefill_flush = excp_flush & (cmt_i[0].ecode == ECODE_TLBR);
    redirect_flush  = cmt_valid_i[0] & cmt_i[0].br_redirect;
    ertn_flush      = cmt_valid_i[0] & cmt_i[0].ertn;
    refetch_flush   = cmt_valid_i[0] &
                      (cmt_i[0].ibar | cmt_i[0].priv | cmt_i[0].icacop | cmt_i[0].idle);
    // a faulting idle never executes
    idle_flush      = cmt_valid_i[0] & cmt_i[0].idle & ~cmt_i[0].excp_valid;
    any_flush       = excp_flush | redirect_flush | ertn_flush | refetch_flush;
  end

  // restart address, highest priority first
  always_comb begin
    if (tlbrefill_flush) begin
      restart_target = csr_i.tlbrentry;
    end else if (excp_flush) begin
      restart_target = csr_i.eentry;
    end else if (redirect_flush) begin
      restart_target = cmt_i[0].payload.br_target;
    end else if (ertn_flush) begin
      restart_target = csr_i.era;
    end else begin
      restart_target = cmt_i[0].pc + 32'd4;
    end
  end

  // younger slots only retire when slot 0 lets the group through
  always_comb begin
    retire_mask_o    = cmt_valid_i & {COMMIT_WIDTH{~any_flush}};
    retire_mask_o[0] = cmt_valid_i[0] & ~excp_flush;
  end

  assign excp_cmt_o = excp_flush;
  assign ertn_cmt_o = ertn_flush & ~excp_flush;

  // ======================================================================
  // registered flush and idle lock
  // ======================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flush_valid_q <= 1'b0;
    end else begin
      flush_valid_q <= any_flush;
    end
  end

  always_ff @(posedge clk) begin
    if (any_flush) begin
      flush_target_q <= restart_target;
    end
  end

  // pending interrupt wakes fetch, and also keeps idle from locking
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      idle_lock_q <= 1'b0;
    end else if (int_pending_i) begin
      idle_lock_q <= 1'b0;
    end else if (idle_flush) begin
      idle_lock_q <= 1'b1;
    end
  end

  always_comb begin
    flush_o.valid  = flush_valid_q;
    flush_o.target = flush_target_q;
  end

  assign fetch_en_o = ~idle_lock_q;

endmodule

// ==== tests/commit_assert.sv ====
module commit_assert import commit_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  flush_t    flush_i,
  input  logic      fetch_en_i,
  input  excp_rpt_t excp_rpt_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // ====================================================================
  // commit output protocol
  // ====================================================================
  flush_single_cycle: assert property (
    @(posedge clk) disable iff (!rst_n) flush_i.valid |=> !flush_i.valid
  ) else $error("flush_o.valid stayed high for two cycles");

  fetch_on_after_reset: assert property (
    @(posedge clk) $rose(rst_n) |-> fetch_en_i
  ) else $error("fetch_en_o was low right after reset");

  // every report is also a flush
  report_has_flush: assert property (
    @(posedge clk) disable iff (!rst_n) excp_rpt_i.valid |-> flush_i.valid
  ) else $error("excp_rpt_o.valid without flush_o.valid");

endmodule

bind commit_top commit_assert u_commit_assert (
  .clk        (clk),
  .rst_n      (rst_n),
  .flush_i    (flush_o),
  .fetch_en_i (fetch_en_o),
  .excp_rpt_i (excp_rpt_o)
);

// ==== tests/tb_commit.sv ====
module tb_commit import commit_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  // flag order matches {excp, br, ertn, ibar, priv, icacop, idle}
  localparam logic [6:0] K_NONE   = 7'b0000000;
  localparam logic [6:0] K_EXCP   = 7'b1000000;
  localparam logic [6:0] K_BR     = 7'b0100000;
  localparam logic [6:0] K_ERTN   = 7'b0010000;
  localparam logic [6:0] K_IBAR   = 7'b0001000;
  localparam logic [6:0] K_PRIV   = 7'b0000100;
  localparam logic [6:0] K_ICACOP = 7'b0000010;
  localparam logic [6:0] K_IDLE   = 7'b0000001;

  localparam csr_vec_t CSR = '{32'h1c00_8000, 32'h1c00_f000, 32'h1c00_4440};

  typedef struct packed {
    logic [1:0]  valid;
    cmt_entry_t  e0;
    cmt_entry_t  e1;
    csr_vec_t    csr;
    logic        int_pending;
    areg_t       raddr;
    flush_t      exp_flush;
    logic        exp_fetch;
    excp_rpt_t   exp_rpt;
    free_t [1:0] exp_free;
    preg_t       exp_preg;
  } row_t;

  logic                 clk;
  logic                 rst_n;
  logic [1:0]           cmt_valid;
  cmt_entry_t [1:0]     cmt;
  csr_vec_t             csr;
  logic                 int_pending;
  areg_t                rat_raddr;
  flush_t               flush;
  logic                 fetch_en;
  excp_rpt_t            rpt;
  free_t [1:0]          free_slots;
  preg_t                rat_rdata;

  row_t        rows[$];
  logic [15:0] lfsr = 16'd61;

  commit_top #(
    .COMMIT_WIDTH (2)
  ) dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .cmt_valid_i   (cmt_valid),
    .cmt_i         (cmt),
    .csr_i         (csr),
    .int_pending_i (int_pending),
    .rat_raddr_i   (rat_raddr),
    .flush_o       (flush),
    .fetch_en_o    (fetch_en),
    .excp_rpt_o    (rpt),
    .free_o        (free_slots),
    .rat_rdata_o   (rat_rdata)
  );

  always #5 clk = ~clk;

  // ====================================================================
  // stimulus helpers
  // ====================================================================
  // taps 16, 14, 13, 11
  function automatic logic [31:0] rand_word(int nbits);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < nbits; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic logic [31:0] rand_pc();
    logic [31:0] w;
    w = rand_word(30);
    return {w[29:0], 2'b00};
  endfunction

  function automatic cmt_entry_t make_entry(logic [31:0] pc, logic [31:0] payload,
                                            logic [6:0] kind, ecode_e ec, areg_t ar,
                                            preg_t pr, preg_t opr);
    cmt_entry_t e;
    e = '0;
    e.pc = pc;
    e.payload.br_target = payload;
    {e.excp_valid, e.br_redirect, e.ertn, e.ibar, e.priv, e.icacop, e.idle} = kind;
    e.ecode = ec;
    e.arch_reg = ar;
    e.phy_reg = pr;
    e.old_phy_reg = opr;
    return e;
  endfunction

  function automatic row_t blank_row();
    row_t r;
    r = '0;
    r.csr = CSR;
    r.exp_fetch = 1'b1;
    return r;
  endfunction

  function automatic free_t free_of(preg_t p);
    return '{1'b1, p};
  endfunction

  function automatic excp_rpt_t excp_expect(logic [31:0] era, ecode_e ec, logic [31:0] va,
                                            logic va_error, logic tlb);
    excp_rpt_t r;
    r = '0;
    r.valid = 1'b1;
    r.tlbrefill = (ec == ECODE_TLBR);
    r.tlb = tlb;
    r.era = era;
    r.ecode = ec;
    r.va_error = va_error;
    r.bad_va = va;
    r.vppn = va[31:13];
    return r;
  endfunction

  // slot 1 is valid but must be squashed by the exception
  task automatic add_excp_row(ecode_e ec, logic [31:0] target, logic [31:0] era_step,
                              logic va_error, logic tlb);
    row_t        r;
    logic [31:0] pc;
    logic [31:0] va;
    r = blank_row();
    pc = rand_pc();
    va = rand_word(32);
    r.valid = 2'b11;
    r.e0 = make_entry(pc, va, K_EXCP, ec, 5'd12, 6'd50, 6'd12);
    r.e1 = make_entry(pc + 32'd4, '0, K_NONE, ECODE_INT, 5'd13, 6'd51, 6'd13);
    r.raddr = 5'd13;
    r.exp_preg = 6'd13;
    r.exp_flush = '{1'b1, target};
    r.exp_rpt = excp_expect(pc + era_step, ec, va, va_error, tlb);
    rows.push_back(r);
  endtask

  task automatic add_refetch_row(logic [6:0] kind, logic int_pending, logic exp_fetch);
    row_t        r;
    logic [31:0] pc;
    r = blank_row();
    pc = rand_pc();
    r.valid = 2'b11;
    r.int_pending = int_pending;
    r.e0 = make_entry(pc, '0, kind, ECODE_INT, 5'd0, 6'd0, 6'd0);
    r.e1 = make_entry(pc + 32'd4, '0, K_NONE, ECODE_INT, 5'd14, 6'd52, 6'd14);
    r.raddr = 5'd14;
    r.exp_preg = 6'd14;
    r.exp_flush = '{1'b1, pc + 32'd4};
    r.exp_fetch = exp_fetch;
    rows.push_back(r);
  endtask

  task automatic add_quiet_row(logic int_pending, logic exp_fetch);
    row_t r;
    r = blank_row();
    r.int_pending = int_pending;
    r.exp_fetch = exp_fetch;
    rows.push_back(r);
  endtask

  task automatic build_table();
    row_t        r;
    logic [31:0] pc;
    logic [31:0] tgt;
    // two plain retirements
    r = blank_row();
    pc = rand_pc();
    r.valid = 2'b11;
    r.e0 = make_entry(pc, '0, K_NONE, ECODE_INT, 5'd5, 6'd40, 6'd5);
    r.e1 = make_entry(pc + 32'd4, '0, K_NONE, ECODE_INT, 5'd6, 6'd41, 6'd6);
    r.raddr = 5'd5;
    r.exp_preg = 6'd40;
    r.exp_free = {free_of(6'd6), free_of(6'd5)};
    rows.push_back(r);
    // same destination in both slots
    r.e0 = make_entry(pc + 32'd8, '0, K_NONE, ECODE_INT, 5'd7, 6'd42, 6'd7);
    r.e1 = make_entry(pc + 32'd12, '0, K_NONE, ECODE_INT, 5'd7, 6'd43, 6'd42);
    r.raddr = 5'd7;
    r.exp_preg = 6'd43;
    r.exp_free = {free_of(6'd42), free_of(6'd7)};
    rows.push_back(r);
    // r0 destination is ignored
    r.e0 = make_entry(pc + 32'd16, '0, K_NONE, ECODE_INT, 5'd0, 6'd44, 6'd0);
    r.e1 = make_entry(pc + 32'd20, '0, K_NONE, ECODE_INT, 5'd8, 6'd45, 6'd8);
    r.raddr = 5'd0;
    r.exp_preg = 6'd0;
    r.exp_free = {free_of(6'd8), free_t'('0)};
    rows.push_back(r);
    add_excp_row(ECODE_TLBR, CSR.tlbrentry, 32'd0, 1'b1, 1'b1);
    add_excp_row(ECODE_SYS, CSR.eentry, 32'd4, 1'b0, 1'b0);
    add_excp_row(ECODE_BRK, CSR.eentry, 32'd4, 1'b0, 1'b0);
    add_excp_row(ECODE_ADE, CSR.eentry, 32'd0, 1'b1, 1'b0);
    add_excp_row(ECODE_PIF, CSR.eentry, 32'd0, 1'b1, 1'b1);
    // redirect retires slot 0 only
    r = blank_row();
    pc = rand_pc();
    tgt = rand_pc();
    r.valid = 2'b11;
    r.e0 = make_entry(pc, tgt, K_BR, ECODE_INT, 5'd10, 6'd48, 6'd10);
    r.e1 = make_entry(tgt, '0, K_NONE, ECODE_INT, 5'd11, 6'd49, 6'd11);
    r.raddr = 5'd11;
    r.exp_preg = 6'd11;
    r.exp_flush = '{1'b1, tgt};
    r.exp_free = {free_t'('0), free_of(6'd10)};
    rows.push_back(r);
    // exception return
    r = blank_row();
    r.valid = 2'b01;
    r.e0 = make_entry(rand_pc(), '0, K_ERTN, ECODE_INT, 5'd0, 6'd0, 6'd0);
    r.raddr = 5'd10;
    r.exp_preg = 6'd48;
    r.exp_flush = '{1'b1, CSR.era};
    r.exp_rpt.valid = 1'b1;
    r.exp_rpt.ertn = 1'b1;
    rows.push_back(r);
    add_refetch_row(K_IBAR, 1'b0, 1'b1);
    add_refetch_row(K_PRIV, 1'b0, 1'b1);
    add_refetch_row(K_ICACOP, 1'b0, 1'b1);
    // idle lock then wake up
    add_refetch_row(K_IDLE, 1'b0, 1'b0);
    add_quiet_row(1'b0, 1'b0);
    add_quiet_row(1'b1, 1'b1);
    add_refetch_row(K_IDLE, 1'b1, 1'b1);
  endtask

  // ====================================================================
  // checks
  // ====================================================================
  task automatic stop_with_failure(string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_flush(flush_t exp, flush_t act);
    if (act.valid !== exp.valid || (exp.valid && act.target !== exp.target)) begin
      stop_with_failure($sformatf("error at %0t: flush_o expected %h actual %h",
                                  $time, exp, act));
    end
  endtask

  task automatic check_rpt(excp_rpt_t exp, excp_rpt_t act);
    logic bad;
    bad = {act.valid, act.ertn, act.tlbrefill, act.tlb, act.va_error} !==
          {exp.valid, exp.ertn, exp.tlbrefill, exp.tlb, exp.va_error};
    // payload fields only mean something for a real exception
    if (exp.valid && !exp.ertn) begin
      bad = bad || act.era !== exp.era || act.ecode !== exp.ecode ||
            act.bad_va !== exp.bad_va || act.vppn !== exp.vppn;
    end
    if (bad) begin
      stop_with_failure($sformatf("error at %0t: excp_rpt_o expected %h actual %h",
                                  $time, exp, act));
    end
  endtask

  task automatic check_free(string name, free_t exp, free_t act);
    if (act.valid !== exp.valid || (exp.valid && act.preg !== exp.preg)) begin
      stop_with_failure($sformatf("error at %0t: %s expected %h actual %h",
                                  $time, name, exp, act));
    end
  endtask

  task automatic check_preg(string name, preg_t exp, preg_t act);
    if (act !== exp) begin
      stop_with_failure($sformatf("error at %0t: %s expected %0d actual %0d",
                                  $time, name, exp, act));
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (act !== exp) begin
      stop_with_failure($sformatf("error at %0t: %s expected %b actual %b",
                                  $time, name, exp, act));
    end
  endtask

  // strobes are single-cycle pulses
  task automatic verify_quiet_outputs();
    check_bit("flush_o.valid", 1'b0, flush.valid);
    check_bit("excp_rpt_o.valid", 1'b0, rpt.valid);
    check_bit("free_o[0].valid", 1'b0, free_slots[0].valid);
    check_bit("free_o[1].valid", 1'b0, free_slots[1].valid);
  endtask

  // ====================================================================
  // run
  // ====================================================================
  task automatic wait_for_reset();
    int n;
    n = 0;
    while (rst_n !== 1'b1 && n < 40) begin
      @(negedge clk);
      n++;
    end
    if (rst_n !== 1'b1) begin
      stop_with_failure("reset was never released");
    end
  endtask

  task automatic run_table();
    foreach (rows[i]) begin
      cmt_valid = rows[i].valid;
      cmt[0] = rows[i].e0;
      cmt[1] = rows[i].e1;
      csr = rows[i].csr;
      int_pending = rows[i].int_pending;
      rat_raddr = rows[i].raddr;
      @(negedge clk);
      check_flush(rows[i].exp_flush, flush);
      check_bit("fetch_en_o", rows[i].exp_fetch, fetch_en);
      check_rpt(rows[i].exp_rpt, rpt);
      check_free("free_o[0]", rows[i].exp_free[0], free_slots[0]);
      check_free("free_o[1]", rows[i].exp_free[1], free_slots[1]);
      check_preg("rat_rdata_o", rows[i].exp_preg, rat_rdata);
      // bubble keeps flush pulses apart
      cmt_valid = '0;
      @(negedge clk);
      verify_quiet_outputs();
    end
  endtask

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    cmt_valid = '0;
    cmt = '0;
    csr = CSR;
    int_pending = 1'b0;
    rat_raddr = '0;
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
  end

  initial begin
    build_table();
    wait_for_reset();
    check_bit("fetch_en_o", 1'b1, fetch_en);
    verify_quiet_outputs();
    run_table();
    $display("Done: no errors");
    $finish;
  end

endmodule
